/* logic/mbRequestSequencer.sv */
// One request in flight; memValid drops for a cycle between words so pending is seen after the clear
`timescale 1ns/1ns

module mbRequestSequencer (
  input  logic                                               clk,
  input  logic                                               rst,
  input  logic [mbxPkg::numWords-1:0]                        pending,
  input  logic [mbxPkg::numWords-1:0][mbxPkg::wordWidth-1:0] words,
  input  logic [mbxPkg::numWords-1:0]                        parities,
  input  logic                                               isWrite,
  input  logic                                               memReady,
  output mbxPkg::memReqT                                     memReq,
  output logic                                               memValid,
  output logic                                               grantValid,
  output logic [mbxPkg::wordIdxWidth-1:0]                    grantIdx
);

  logic [mbxPkg::wordIdxWidth-1:0] lowIdx;
  logic [mbxPkg::wordIdxWidth-1:0] selIdx;
  logic                            anyPending;

  //////////////////////////////
  // Priority encoder
  //////////////////////////////

  // Lowest word number wins
  always_comb begin
    lowIdx = '0;
    for (int i = mbxPkg::numWords - 1; i >= 0; i--) begin
      if (pending[i]) begin
        lowIdx = mbxPkg::wordIdxWidth'(i);
      end
    end
  end

  assign anyPending = |pending;

  //////////////////////////////
  // Select hold and release
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      memValid <= 1'b0;
      selIdx   <= '0;
    end else if (memValid) begin
      // Hold selection until memory takes it
      if (memReady) begin
        memValid <= 1'b0;
      end
    end else if (anyPending) begin
      memValid <= 1'b1;
      selIdx   <= lowIdx;
    end
  end

  // Grant pulses on the accept edge
  assign grantValid = memValid & memReady;
  assign grantIdx   = selIdx;

  //////////////////////////////
  // Memory request
  //////////////////////////////

  always_comb begin
    memReq.wordIdx = selIdx;
    memReq.isWrite = isWrite;
    // Reads carry no data
    memReq.data    = isWrite ? words[selIdx] : '0;
    memReq.parity  = isWrite ? parities[selIdx] : 1'b0;
  end

endmodule

/* logic/mbWordRequest.sv */
// Holds at most one decoded block; commands with an empty word mask are accepted and dropped
`timescale 1ns/1ns

module mbWordRequest (
  input  logic             clk,
  input  logic             rst,
  input  mbxPkg::cycleCmdT cmd,
  input  logic             cmdValid,
  input  logic             loadReady,
  output logic             cmdReady,
  output mbxPkg::bufLoadT  load,
  output logic             loadValid
);

  logic [mbxPkg::numWords-1:0] reqMask;
  logic                        isWrite;
  logic                        cmdFire;
  logic                        loadFire;

  //////////////////////////////
  // Word request decode
  //////////////////////////////

  always_comb begin
    reqMask = '0;
    isWrite = 1'b0;
    case (cmd.cycType)
      mbxPkg::cycOneWordRd: begin
        // Only the addressed word
        reqMask = mbxPkg::numWords'(1) << cmd.wordAdr;
      end
      mbxPkg::cycBlockRd: begin
        // Refill whatever the cache does not already hold
        reqMask = ~cmd.wdValid;
      end
      mbxPkg::cycWriteback: begin
        reqMask = '1;
        isWrite = 1'b1;
      end
      default: begin
        reqMask = '0;
      end
    endcase
  end

  //////////////////////////////
  // Output stage
  //////////////////////////////

  assign loadFire = loadValid & loadReady;

  // Accept when the stage is empty or drains on this same edge
  assign cmdReady = ~loadValid | loadReady;
  assign cmdFire  = cmdValid & cmdReady;

  always_ff @(posedge clk) begin
    if (rst) begin
      loadValid <= 1'b0;
    end else if (cmdFire) begin
      // Empty masks never reach the buffer
      loadValid <= |reqMask;
    end else if (loadFire) begin
      loadValid <= 1'b0;
    end
  end

  // Payload is only meaningful while loadValid is high
  always_ff @(posedge clk) begin
    if (cmdFire) begin
      load.reqMask <= reqMask;
      load.isWrite <= isWrite;
      load.data    <= cmd.data;
    end
  end

endmodule

/* logic/mbxControl.sv */
// Command to first memValid takes at least three cycles; only one block drains at a time
`timescale 1ns/1ns

module mbxControl (
  input  logic             clk,
  input  logic             rst,
  input  mbxPkg::cycleCmdT cmd,
  input  logic             cmdValid,
  input  logic             memReady,
  output logic             cmdReady,
  output mbxPkg::memReqT   memReq,
  output logic             memValid
);

  // Generator to buffer
  mbxPkg::bufLoadT                                    load;
  logic                                               loadValid;
  logic                                               loadReady;

  // Buffer to sequencer
  logic [mbxPkg::numWords-1:0]                        pending;
  logic [mbxPkg::numWords-1:0][mbxPkg::wordWidth-1:0] words;
  logic [mbxPkg::numWords-1:0]                        parities;
  logic                                               isWrite;
  logic                                               grantValid;
  logic [mbxPkg::wordIdxWidth-1:0]                    grantIdx;

  mbWordRequest i_mbWordRequest (
    .clk       (clk),
    .rst       (rst),
    .cmd       (cmd),
    .cmdValid  (cmdValid),
    .loadReady (loadReady),
    .cmdReady  (cmdReady),
    .load      (load),
    .loadValid (loadValid)
  );

  memBuffer i_memBuffer (
    .clk        (clk),
    .rst        (rst),
    .load       (load),
    .loadValid  (loadValid),
    .grantValid (grantValid),
    .grantIdx   (grantIdx),
    .loadReady  (loadReady),
    .pending    (pending),
    .words      (words),
    .parities   (parities),
    .isWrite    (isWrite)
  );

  mbRequestSequencer i_mbRequestSequencer (
    .clk        (clk),
    .rst        (rst),
    .pending    (pending),
    .words      (words),
    .parities   (parities),
    .isWrite    (isWrite),
    .memReady   (memReady),
    .memReq     (memReq),
    .memValid   (memValid),
    .grantValid (grantValid),
    .grantIdx   (grantIdx)
  );

endmodule

/* logic/mbxPkg.sv */
// Fixed at four 36-bit words per block; all widths here are shared by RTL and testbench
package mbxPkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  // Words in one memory buffer block
  localparam int numWords = 4;

  // Width of one memory data word
  localparam int wordWidth = 36;

  // Width of a word number inside the block
  localparam int wordIdxWidth = 2;

  //////////////////////////////
  // Cycle types
  //////////////////////////////

  // Encoding 2'b11 is unused and yields an empty request mask
  typedef enum logic [1:0] {
    cycOneWordRd = 2'b00,
    cycBlockRd   = 2'b01,
    cycWriteback = 2'b10
  } cycleTypeE;

  //////////////////////////////
  // Transfer records
  //////////////////////////////

  // Cache cycle command as it arrives from the cache side
  typedef struct packed {
    cycleTypeE                                 cycType;
    logic [wordIdxWidth-1:0]                   wordAdr;
    logic [numWords-1:0]                       wdValid;
    logic [numWords-1:0][wordWidth-1:0]        data;
  } cycleCmdT;

  // Decoded block handed from the request generator to the buffer
  typedef struct packed {
    logic [numWords-1:0]                       reqMask;
    logic                                      isWrite;
    logic [numWords-1:0][wordWidth-1:0]        data;
  } bufLoadT;

  // One word request presented to memory
  typedef struct packed {
    logic [wordIdxWidth-1:0]                   wordIdx;
    logic                                      isWrite;
    logic [wordWidth-1:0]                      data;
    logic                                      parity;
  } memReqT;

endpackage

/* logic/memBuffer.sv */
// Accepts a new block only when no word is pending; grant and load never meet on one edge
`timescale 1ns/1ns

module memBuffer (
  input  logic                                               clk,
  input  logic                                               rst,
  input  mbxPkg::bufLoadT                                    load,
  input  logic                                               loadValid,
  input  logic                                               grantValid,
  input  logic [mbxPkg::wordIdxWidth-1:0]                    grantIdx,
  output logic                                               loadReady,
  output logic [mbxPkg::numWords-1:0]                        pending,
  output logic [mbxPkg::numWords-1:0][mbxPkg::wordWidth-1:0] words,
  output logic [mbxPkg::numWords-1:0]                        parities,
  output logic                                               isWrite
);

  logic                              loadFire;
  logic [mbxPkg::numWords-1:0]       loadParity;
  logic [mbxPkg::numWords-1:0]       grantMask;

  // Buffer takes a block only once every request has gone out
  assign loadReady = ~|pending;
  assign loadFire  = loadValid & loadReady;

  //////////////////////////////
  // Parity generation
  //////////////////////////////

  // Even parity so that data plus parity holds an even count of ones
  always_comb begin
    for (int i = 0; i < mbxPkg::numWords; i++) begin
      loadParity[i] = ^load.data[i];
    end
  end

  // One-hot of the word being granted
  always_comb begin
    grantMask = '0;
    if (grantValid) begin
      grantMask = mbxPkg::numWords'(1) << grantIdx;
    end
  end

  //////////////////////////////
  // Pending request flags
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else if (loadFire) begin
      pending <= load.reqMask;
    end else begin
      // Grant clears its word on the accept edge
      pending <= pending & ~grantMask;
    end
  end

  //////////////////////////////
  // Data, parity and direction
  //////////////////////////////

  // Held for the whole block until the next load
  always_ff @(posedge clk) begin
    if (loadFire) begin
      words    <= load.data;
      parities <= loadParity;
      isWrite  <= load.isWrite;
    end
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Compile the mbxControl testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert -j 0 \
  --top-module mbxControlTb \
  -f verilog.f \
  -o simMbxControl

# A failing assertion stops the simulator, so its status is not used here
output=$(./obj_dir/simMbxControl 2>&1 || true)
echo "$output"

if grep -qx "TEST RESULT: PASS" <<< "$output"; then
  exit 0
else
  echo "Simulation did not pass"
  exit 1
fi

/* tb/mbxControlTb.sv */
// Drives commands on rising edges and predicts every memory request; readyMode sets memory stalls
`timescale 1ns/1ns

module mbxControlTb;

  logic             clk;
  logic             rst;
  mbxPkg::cycleCmdT cmd;
  logic             cmdValid;
  logic             memReady;
  logic             cmdReady;
  mbxPkg::memReqT   memReq;
  logic             memValid;

  // 0 always ready, 1 random stalls, 2 held low
  int               readyMode;
  integer           seed;
  integer           stallSeed;
  string            curTest;

  // Predicted requests in the order memory should see them
  mbxPkg::memReqT   expQ[$];
  string            expTestQ[$];

  int               compareCount;
  int               mismatchCount;
  int               unexpectedCount;
  int               protocolCount;
  int               timeoutCount;

  mbxControl i_mbxControl (
    .clk      (clk),
    .rst      (rst),
    .cmd      (cmd),
    .cmdValid (cmdValid),
    .memReady (memReady),
    .cmdReady (cmdReady),
    .memReq   (memReq),
    .memValid (memValid)
  );

  always #5 clk = ~clk;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [mbxPkg::numWords-1:0] requestMask(mbxPkg::cycleCmdT c);
    logic [mbxPkg::numWords-1:0] mask;
    mask = '0;
    case (c.cycType)
      mbxPkg::cycOneWordRd: mask[c.wordAdr] = 1'b1;
      mbxPkg::cycBlockRd:   mask = ~c.wdValid;
      mbxPkg::cycWriteback: mask = '1;
      default:              mask = '0;
    endcase
    return mask;
  endfunction

  task automatic predictRequests(mbxPkg::cycleCmdT c, string name);
    logic [mbxPkg::numWords-1:0] mask;
    mbxPkg::memReqT              req;
    mask = requestMask(c);
    for (int i = 0; i < mbxPkg::numWords; i++) begin
      if (mask[i]) begin
        req.wordIdx = mbxPkg::wordIdxWidth'(i);
        req.isWrite = (c.cycType == mbxPkg::cycWriteback);
        req.data    = req.isWrite ? c.data[i] : '0;
        req.parity  = req.isWrite ? ^c.data[i] : 1'b0;
        expQ.push_back(req);
        expTestQ.push_back(name);
      end
    end
  endtask

  task automatic compareRequest();
    mbxPkg::memReqT expReq;
    string          name;
    if (expQ.size() == 0) begin
      unexpectedCount++;
      $display("Memory request for word %0d arrived with no request outstanding",
               memReq.wordIdx);
    end else begin
      expReq = expQ.pop_front();
      name   = expTestQ.pop_front();
      compareCount++;
      if (memReq !== expReq) begin
        mismatchCount++;
        $display("[FAIL] %s: expected %h, actual %h", name, expReq, memReq);
      end
    end
  endtask

  // Accepted commands feed the scoreboard
  always @(posedge clk) begin
    if (!rst && cmdValid && cmdReady) begin
      predictRequests(cmd, curTest);
    end
  end

  always @(posedge clk) begin
    if (!rst && memValid && memReady) begin
      compareRequest();
    end
  end

  always @(posedge clk) begin
    case (readyMode)
      0:       memReady <= 1'b1;
      1:       memReady <= ({$random(stallSeed)} % 4) != 0;
      default: memReady <= 1'b0;
    endcase
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  task automatic finishRun();
    int total;
    total = mismatchCount + unexpectedCount + protocolCount + timeoutCount;
    $display("Compared %0d requests: %0d mismatches, %0d unexpected, %0d protocol, %0d timeouts",
             compareCount, mismatchCount, unexpectedCount, protocolCount, timeoutCount);
    if (total == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  task automatic checkBit(string name, logic expBit, logic actBit);
    if (actBit !== expBit) begin
      protocolCount++;
      $display("[FAIL] %s: expected %0b, actual %0b", name, expBit, actBit);
    end
  endtask

  function automatic mbxPkg::cycleCmdT makeCmd(mbxPkg::cycleTypeE t,
                                               logic [mbxPkg::wordIdxWidth-1:0] adr,
                                               logic [mbxPkg::numWords-1:0] valid,
                                               logic [mbxPkg::wordWidth-1:0] base);
    mbxPkg::cycleCmdT c;
    c.cycType = t;
    c.wordAdr = adr;
    c.wdValid = valid;
    for (int i = 0; i < mbxPkg::numWords; i++) begin
      c.data[i] = base ^ (36'h1_1111_1111 * mbxPkg::wordWidth'(i));
    end
    return c;
  endfunction

  task automatic randomCmd(output mbxPkg::cycleCmdT c);
    logic [31:0] r;
    logic [63:0] d;
    r = {$random(seed)} % 3;
    c.cycType = mbxPkg::cycleTypeE'(r[1:0]);
    r = $random(seed);
    c.wordAdr = r[1:0];
    c.wdValid = r[7:4];
    for (int i = 0; i < mbxPkg::numWords; i++) begin
      d = {$random(seed), $random(seed)};
      c.data[i] = d[mbxPkg::wordWidth-1:0];
    end
  endtask

  task automatic waitAccept();
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    while (!done && waited < 300) begin
      @(posedge clk);
      waited++;
      if (cmdReady) begin
        done = 1'b1;
      end
    end
    cmdValid <= 1'b0;
    if (!done) begin
      timeoutCount++;
      $display("Timeout: command of test %s was not accepted in 300 cycles", curTest);
    end
  endtask

  task automatic sendCmd(mbxPkg::cycleCmdT c);
    cmd      <= c;
    cmdValid <= 1'b1;
    waitAccept();
  endtask

  task automatic drainWait();
    int waited;
    waited = 0;
    // Scoreboard sees the last accepted command before the queue is judged
    @(posedge clk);
    while (expQ.size() != 0 && waited < 600) begin
      @(posedge clk);
      waited++;
    end
    if (expQ.size() != 0) begin
      timeoutCount++;
      $display("Timeout: %0d predicted requests never reached memory in test %s",
               expQ.size(), curTest);
    end
    // Room for any stray request to show up
    repeat (6) @(posedge clk);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    mbxPkg::cycleCmdT c;
    logic             leaked;
    clk             = 1'b0;
    rst             = 1'b1;
    cmd             = '0;
    cmdValid        = 1'b0;
    memReady        = 1'b0;
    readyMode       = 0;
    seed            = 10;
    stallSeed       = 10;
    curTest         = "reset";
    compareCount    = 0;
    mismatchCount   = 0;
    unexpectedCount = 0;
    protocolCount   = 0;
    timeoutCount    = 0;

    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    checkBit("reset cmdReady", 1'b1, cmdReady);
    checkBit("reset memValid", 1'b0, memValid);

    curTest = "oneWordRd";
    sendCmd(makeCmd(mbxPkg::cycOneWordRd, 2'd2, 4'b0000, 36'h0_0000_0000));
    sendCmd(makeCmd(mbxPkg::cycOneWordRd, 2'd0, 4'b1111, 36'h0_0000_0000));
    drainWait();

    curTest = "blockRd";
    sendCmd(makeCmd(mbxPkg::cycBlockRd, 2'd0, 4'b0101, 36'h0_0000_0000));
    drainWait();

    // Every word already valid, so nothing may reach memory
    curTest = "blockRdAllValid";
    sendCmd(makeCmd(mbxPkg::cycBlockRd, 2'd0, 4'b1111, 36'h0_0000_0000));
    drainWait();

    curTest = "writeback";
    sendCmd(makeCmd(mbxPkg::cycWriteback, 2'd0, 4'b0000, 36'hF_0123_4567));
    drainWait();

    // One block in the buffer, one in the producer, the third must wait
    curTest   = "backPressure";
    readyMode <= 2;
    sendCmd(makeCmd(mbxPkg::cycWriteback, 2'd0, 4'b0000, 36'h0_AAAA_5555));
    sendCmd(makeCmd(mbxPkg::cycWriteback, 2'd0, 4'b0000, 36'h9_0F0F_F0F0));
    cmd      <= makeCmd(mbxPkg::cycBlockRd, 2'd0, 4'b1000, 36'h0_0000_0000);
    cmdValid <= 1'b1;
    leaked = 1'b0;
    for (int k = 0; k < 20 && !leaked; k++) begin
      @(posedge clk);
      if (cmdReady) begin
        leaked = 1'b1;
        protocolCount++;
        $display("cmdReady stayed high while memory was stalled");
      end
    end
    readyMode <= 1;
    if (leaked) begin
      cmdValid <= 1'b0;
    end else begin
      waitAccept();
    end
    drainWait();

    curTest = "random";
    for (int n = 0; n < 40; n++) begin
      randomCmd(c);
      sendCmd(c);
    end
    drainWait();

    finishRun();
  end

endmodule

/* tb/mbxControl_assertions.sv */
// Protocol checks on the top-level ports; memReq is only judged while memValid is high
`timescale 1ns/1ns

module mbxControl_assertions (
  input logic           clk,
  input logic           rst,
  input logic           cmdReady,
  input logic           memValid,
  input logic           memReady,
  input mbxPkg::memReqT memReq
);

  //////////////////////////////
  // Reset state
  //////////////////////////////

  // Covers every reset cycle and the first cycle after release
  resetIdle: assert property (@(posedge clk) rst |=> (!memValid && cmdReady))
    else $error("memValid high or cmdReady low during or just after reset");

  //////////////////////////////
  // Memory handshake
  //////////////////////////////

  // Request held steady while memory stalls
  stallHold: assert property (@(posedge clk) disable iff (rst)
    (memValid && !memReady) |=> (memValid && $stable(memReq)))
    else $error("memReq changed or memValid dropped while memReady was low");

  // Sequencer releases for a cycle after each accept
  dropAfterAccept: assert property (@(posedge clk) disable iff (rst)
    (memValid && memReady) |=> !memValid)
    else $error("memValid stayed high after memory accepted a request");

  //////////////////////////////
  // Payload
  //////////////////////////////

  writeParity: assert property (@(posedge clk) disable iff (rst)
    (memValid && memReq.isWrite) |-> (memReq.parity == ^memReq.data))
    else $error("write request parity is not even parity of its data");

  // Reads carry neither data nor parity
  readZero: assert property (@(posedge clk) disable iff (rst)
    (memValid && !memReq.isWrite) |-> (memReq.data == '0 && !memReq.parity))
    else $error("read request carries nonzero data or parity");

endmodule

bind mbxControl mbxControl_assertions i_mbxControlAssertions (
  .clk      (clk),
  .rst      (rst),
  .cmdReady (cmdReady),
  .memValid (memValid),
  .memReady (memReady),
  .memReq   (memReq)
);

/* verilog.f */
logic/mbxPkg.sv
logic/mbWordRequest.sv
logic/memBuffer.sv
logic/mbRequestSequencer.sv
logic/mbxControl.sv
tb/mbxControl_assertions.sv
tb/mbxControlTb.sv
